// ==== include/scan_consts.svh ====
/*
 * Global constants for the 48-channel pulse-timing readout.
 * Include in any package or module that needs channel counts,
 * datapath widths or the configuration register location.
 */
`ifndef SCAN_CONSTS_SVH
`define SCAN_CONSTS_SVH

// Channel organisation
`define SCAN_NUM_CHANNELS 48
`define SCAN_GROUP_SIZE   16
`define SCAN_NUM_GROUPS   3

// Datapath widths
`define SCAN_CH_W         6
`define SCAN_WORD_W       32
`define SCAN_ADDR_W       8
`define SCAN_FIELD_W      16

// Configuration register
// bits 5..0 start channel, 13..8 max channel, 16 increment
`define SCAN_CFG_ADDR     8'hC2
`define SCAN_CFG_RESET    32'h00012F00

`endif

// ==== rtl/channelSequencer.sv ====
/*
 * Channel-number counter. Each step strobe either reloads the start
 * channel (when the maximum is reached) or adds the increment bit.
 * With the increment bit clear the channel number holds.
 */
`timescale 1ns/1ns
`include "scan_consts.svh"

module channelSequencer
    import scanTypesPkg::*;
(
    input  logic     next,
    input  logic     rstN,
    input  logic     step,
    input  scanCfg_t cfg,
    output chanNum_t chanNum
);

    always_ff @(posedge next) begin
        if (!rstN) begin
            chanNum <= '0;
        end else if (step) begin
            if (chanNum == cfg.maxChan) begin
                chanNum <= cfg.startChan;
            end else begin
                chanNum <= chanNum + chanNum_t'(cfg.incr);
            end
        end
    end

    // A maximum inside the channel range keeps the scan inside it
    chanInRange: assert property (
        @(posedge next) disable iff (!rstN)
        (cfg.maxChan < `SCAN_NUM_CHANNELS) |-> (chanNum < `SCAN_NUM_CHANNELS)
    );

endmodule

// ==== rtl/localBusIf.sv ====
/*
 * One local-bus access. The master side drives address, write data
 * and strobes; the slave side returns registered read data.
 */
`timescale 1ns/1ns
`include "scan_consts.svh"

interface localBusIf
    import localBusPkg::*;
();

    logic [`SCAN_ADDR_W-1:0] addr;
    busWord_t                wrData;
    logic                    read;
    logic                    write;
    busWord_t                rdData;

    modport master (output addr, output wrData, output read, output write, input rdData);

    modport slave (input addr, input wrData, input read, input write, output rdData);

endinterface

// ==== rtl/localBusPkg.sv ====
/*
 * Local bus types. The operation enum is decoded from the
 * single-cycle read and write strobes.
 */
`include "scan_consts.svh"

package localBusPkg;

    typedef logic [`SCAN_WORD_W-1:0] busWord_t;

    typedef enum logic [1:0] {
        BUS_IDLE,
        BUS_READ,
        BUS_WRITE
    } busOp_e;

endpackage

// ==== rtl/pulseChannel.sv ====
/*
 * One readout channel. The input is registered once, the length of
 * each high pulse is counted in clock cycles (saturating), and on the
 * falling edge the width and a wrapping pulse count are published in
 * the result word.
 */
`timescale 1ns/1ns
`include "scan_consts.svh"

module pulseChannel
    import scanTypesPkg::*;
(
    input  logic        next,
    input  logic        rstN,
    input  logic        din,
    output chanResult_t chanResult
);

    measState_e               state;
    logic                     dinReg;
    logic [`SCAN_FIELD_W-1:0] widthCnt;

    always_ff @(posedge next) begin
        if (!rstN) begin
            dinReg <= 1'b0;
        end else begin
            dinReg <= din;
        end
    end

    //------------------------------------------------------------
    // Pulse measurement FSM
    //------------------------------------------------------------
    always_ff @(posedge next) begin
        if (!rstN) begin
            state      <= IDLE_LOW;
            widthCnt   <= '0;
            chanResult <= '0;
        end else begin
            case (state)
                IDLE_LOW: begin
                    if (dinReg) begin
                        state    <= IN_PULSE;
                        widthCnt <= {{(`SCAN_FIELD_W-1){1'b0}}, 1'b1};
                    end
                end
                IN_PULSE: begin
                    if (dinReg) begin
                        // Stick at full scale on very long pulses
                        if (widthCnt != '1) begin
                            widthCnt <= widthCnt + 1'b1;
                        end
                    end else begin
                        state                 <= IDLE_LOW;
                        chanResult.lastWidth  <= widthCnt;
                        chanResult.pulseCount <= chanResult.pulseCount + 1'b1;
                    end
                end
                default: state <= IDLE_LOW;
            endcase
        end
    end

endmodule

// ==== rtl/resultMux.sv ====
/*
 * Registered two-level selection of one channel's result word.
 * Stage one picks a word from each group of 16 using the low channel
 * bits; stage two picks the group using the upper bits, which are
 * carried alongside. Result lags the channel number by two cycles.
 */
`timescale 1ns/1ns
`include "scan_consts.svh"

module resultMux
    import scanTypesPkg::*;
(
    input  logic                                     next,
    input  logic                                     rstN,
    input  chanResult_t [`SCAN_NUM_CHANNELS-1:0]     chanResults,
    input  chanNum_t                                 chanNum,
    output chanResult_t                              result
);

    localparam int GROUP_SEL_W = `SCAN_CH_W - 4;

    chanResult_t [`SCAN_NUM_GROUPS-1:0] groupWord;
    logic [GROUP_SEL_W-1:0]             groupSel;
    logic [3:0]                         memberSel;

    assign memberSel = chanNum[3:0];

    //------------------------------------------------------------
    // Stage one: 16-to-1 within each group
    //------------------------------------------------------------
    always_ff @(posedge next) begin
        if (!rstN) begin
            groupWord <= '0;
            groupSel  <= '0;
        end else begin
            for (int g = 0; g < `SCAN_NUM_GROUPS; g++) begin
                groupWord[g] <= chanResults[g * `SCAN_GROUP_SIZE + int'(memberSel)];
            end
            groupSel <= chanNum[`SCAN_CH_W-1 -: GROUP_SEL_W];
        end
    end

    //------------------------------------------------------------
    // Stage two: 3-to-1 across groups
    //------------------------------------------------------------
    always_ff @(posedge next) begin
        if (!rstN) begin
            result <= '0;
        end else begin
            case (groupSel)
                2'd0:    result <= groupWord[0];
                2'd1:    result <= groupWord[1];
                2'd2:    result <= groupWord[2];
                default: result <= '0;
            endcase
        end
    end

    // Channel numbers above 47 would address a missing fourth group
    groupSelValid: assert property (
        @(posedge next) disable iff (!rstN) groupSel != 2'd3
    );

endmodule

// ==== rtl/scanConfigReg.sv ====
/*
 * Bus-accessible configuration register for the channel sequencer.
 * Writes land on the clock edge of a matching write strobe; reads are
 * registered and hold until the next read strobe. Other addresses
 * read back as zero.
 */
`timescale 1ns/1ns
`include "scan_consts.svh"

module scanConfigReg
    import scanTypesPkg::*;
    import localBusPkg::*;
(
    input  logic      next,
    input  logic      rstN,
    localBusIf.slave  bus,
    output scanCfg_t  cfg
);

    busWord_t cfgReg;
    busOp_e   busOp;
    logic     addrHit;

    assign addrHit = (bus.addr == `SCAN_CFG_ADDR);

    always_comb begin
        if (bus.write) begin
            busOp = BUS_WRITE;
        end else if (bus.read) begin
            busOp = BUS_READ;
        end else begin
            busOp = BUS_IDLE;
        end
    end

    //------------------------------------------------------------
    // Register and read-back
    //------------------------------------------------------------
    always_ff @(posedge next) begin
        if (!rstN) begin
            cfgReg     <= `SCAN_CFG_RESET;
            bus.rdData <= '0;
        end else begin
            case (busOp)
                BUS_WRITE: if (addrHit) cfgReg <= bus.wrData;
                BUS_READ:  bus.rdData <= addrHit ? cfgReg : '0;
                default:   ;
            endcase
        end
    end

    // Field decode for the sequencer
    assign cfg.startChan = cfgReg[5:0];
    assign cfg.maxChan   = cfgReg[13:8];
    assign cfg.incr      = cfgReg[16];

    // Master must never issue both strobes together
    busStrobeExclusive: assert property (
        @(posedge next) disable iff (!rstN) !(bus.read && bus.write)
    );

endmodule

// ==== rtl/scanTop.sv ====
/*
 * Top level of the pulse-timing readout. Connects the local-bus pins
 * to the configuration register, runs the channel sequencer on the
 * step strobe and presents the selected channel's result word.
 * Channel number is also driven on sw for external monitoring.
 */
`timescale 1ns/1ns
`include "scan_consts.svh"

module scanTop
    import scanTypesPkg::*;
(
    input  logic                          next,
    input  logic                          rstN,
    input  logic [`SCAN_NUM_CHANNELS-1:0] din,
    input  logic                          step,
    input  logic [`SCAN_ADDR_W-1:0]       addr,
    input  logic [`SCAN_WORD_W-1:0]       dataIn,
    input  logic                          read,
    input  logic                          write,
    output logic [`SCAN_WORD_W-1:0]       dataOut,
    output logic [`SCAN_WORD_W-1:0]       result,
    output logic [`SCAN_CH_W-1:0]         sw
);

    scanCfg_t                               cfg;
    chanNum_t                               chanNum;
    chanResult_t [`SCAN_NUM_CHANNELS-1:0]   chanResults;
    chanResult_t                            resultWord;

    //------------------------------------------------------------
    // Local bus
    //------------------------------------------------------------
    localBusIf bus ();

    assign bus.addr   = addr;
    assign bus.wrData = dataIn;
    assign bus.read   = read;
    assign bus.write  = write;
    assign dataOut    = bus.rdData;

    scanConfigReg cfgReg_i (
        .next (next),
        .rstN (rstN),
        .bus  (bus.slave),
        .cfg  (cfg)
    );

    //------------------------------------------------------------
    // Channel selection
    //------------------------------------------------------------
    channelSequencer seq_i (
        .next    (next),
        .rstN    (rstN),
        .step    (step),
        .cfg     (cfg),
        .chanNum (chanNum)
    );

    assign sw = chanNum;

    // One measurement block per input
    for (genvar ch = 0; ch < `SCAN_NUM_CHANNELS; ch++) begin : genChan
        pulseChannel chan_i (
            .next       (next),
            .rstN       (rstN),
            .din        (din[ch]),
            .chanResult (chanResults[ch])
        );
    end

    resultMux mux_i (
        .next        (next),
        .rstN        (rstN),
        .chanResults (chanResults),
        .chanNum     (chanNum),
        .result      (resultWord)
    );

    assign result = resultWord;

endmodule

// ==== rtl/scanTypesPkg.sv ====
/*
 * Types shared by the scan datapath: channel numbers, the decoded
 * sequencer configuration, the per-channel result word and the
 * channel measurement states.
 */
`include "scan_consts.svh"

package scanTypesPkg;

    typedef logic [`SCAN_CH_W-1:0] chanNum_t;

    // Decoded fields of the configuration register
    typedef struct packed {
        chanNum_t startChan;
        chanNum_t maxChan;
        logic     incr;
    } scanCfg_t;

    // Width in the upper half, pulse count in the lower half
    typedef struct packed {
        logic [`SCAN_FIELD_W-1:0] lastWidth;
        logic [`SCAN_FIELD_W-1:0] pulseCount;
    } chanResult_t;

    typedef enum logic {
        IDLE_LOW,
        IN_PULSE
    } measState_e;

endpackage

// ==== src.f ====
+incdir+include
rtl/scanTypesPkg.sv
rtl/localBusPkg.sv
rtl/localBusIf.sv
rtl/scanConfigReg.sv
rtl/channelSequencer.sv
rtl/pulseChannel.sv
rtl/resultMux.sv
rtl/scanTop.sv
testbench/scanChecker.sv
testbench/scanTb.sv

// ==== testbench/scanChecker.sv ====
/*
 * Result checker for the pulse-timing readout testbench. On each check
 * strobe it samples the chosen DUT output at the falling clock edge,
 * compares it with the expected word and prints one line per test.
 * Also flags unknown values on the outputs once reset is released.
 */
`timescale 1ns/1ns
`include "scan_consts.svh"

module scanChecker (
    input  logic                    next,
    input  logic                    rstN,
    input  logic                    checkEn,
    input  logic [1:0]              checkKind,
    input  logic [`SCAN_WORD_W-1:0] expVal,
    input  logic [191:0]            checkName,
    input  logic [`SCAN_WORD_W-1:0] dataOut,
    input  logic [`SCAN_WORD_W-1:0] result,
    input  logic [`SCAN_CH_W-1:0]   sw,
    output int                      passCount,
    output int                      failCount
);

    localparam logic [1:0] KIND_BUS    = 2'd0;
    localparam logic [1:0] KIND_SW     = 2'd1;
    localparam logic [1:0] KIND_RESULT = 2'd2;

    logic [`SCAN_WORD_W-1:0] actual;

    initial begin
        passCount = 0;
        failCount = 0;
    end

    // Output under test for the current check
    always_comb begin
        case (checkKind)
            KIND_BUS:    actual = dataOut;
            KIND_SW:     actual = {{(`SCAN_WORD_W-`SCAN_CH_W){1'b0}}, sw};
            KIND_RESULT: actual = result;
            default:     actual = 'x;
        endcase
    end

    //------------------------------------------------------------
    // Compare on the falling edge, away from DUT updates
    //------------------------------------------------------------
    always @(negedge next) begin
        if (checkEn) begin
            if (checkKind == 2'd3) begin
                $display("Check %0s asked for an unknown output", checkName);
                failCount++;
            end else if (actual === expVal) begin
                $display("PASS %0s: %h", checkName, actual);
                passCount++;
            end else begin
                $display("FAIL %0s: expected %h, actual %h", checkName, expVal, actual);
                failCount++;
            end
        end
    end

    // Outputs must never go unknown outside reset
    always @(negedge next) begin
        if (rstN && (^{dataOut, result, sw} === 1'bx)) begin
            $display("DUT output went unknown at time %0t", $time);
            failCount++;
        end
    end

endmodule

// ==== testbench/scanTb.sv ====
/*
 * Testbench for the pulse-timing readout. Reads test records from
 * testbench/scan_input.txt, drives bus accesses, steps and input pulses
 * into scanTop and hands each expected value to scanChecker.
 * Random idle gaps separate the records.
 */
`timescale 1ns/1ns
`include "scan_consts.svh"

module scanTb;

    localparam int MAX_RECORDS       = 64;
    localparam int CYCLES_PER_RECORD = 64;
    localparam int PULSE_SETTLE      = 8;

    localparam logic [1:0] KIND_BUS    = 2'd0;
    localparam logic [1:0] KIND_SW     = 2'd1;
    localparam logic [1:0] KIND_RESULT = 2'd2;

    logic                          next;
    logic                          rstN;
    logic [`SCAN_NUM_CHANNELS-1:0] din;
    logic                          step;
    logic [`SCAN_ADDR_W-1:0]       addr;
    logic [`SCAN_WORD_W-1:0]       dataIn;
    logic                          read;
    logic                          write;
    logic [`SCAN_WORD_W-1:0]       dataOut;
    logic [`SCAN_WORD_W-1:0]       result;
    logic [`SCAN_CH_W-1:0]         sw;

    logic                          checkEn;
    logic [1:0]                    checkKind;
    logic [`SCAN_WORD_W-1:0]       expVal;
    logic [191:0]                  checkName;
    int                            passCount;
    int                            failCount;

    // Test records
    reg [63:0]  opArr   [0:MAX_RECORDS-1];
    reg [31:0]  arg1Arr [0:MAX_RECORDS-1];
    reg [31:0]  arg2Arr [0:MAX_RECORDS-1];
    reg [31:0]  expArr  [0:MAX_RECORDS-1];
    reg [191:0] nameArr [0:MAX_RECORDS-1];

    int     recCount;
    int     cycleCount;
    int     cycleLimit;
    int     stimFails;
    int     idx;
    int     gap;
    integer seed;

    scanTop dut_i (
        .next    (next),
        .rstN    (rstN),
        .din     (din),
        .step    (step),
        .addr    (addr),
        .dataIn  (dataIn),
        .read    (read),
        .write   (write),
        .dataOut (dataOut),
        .result  (result),
        .sw      (sw)
    );

    scanChecker checker_i (
        .next      (next),
        .rstN      (rstN),
        .checkEn   (checkEn),
        .checkKind (checkKind),
        .expVal    (expVal),
        .checkName (checkName),
        .dataOut   (dataOut),
        .result    (result),
        .sw        (sw),
        .passCount (passCount),
        .failCount (failCount)
    );

    always #2 next = ~next;

    // Timeout guard
    always @(posedge next) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            $display("Timeout: run stopped after %0d cycles", cycleCount);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    //------------------------------------------------------------
    // Record loading
    //------------------------------------------------------------
    task automatic loadRecords;
        integer         fd;
        integer         n;
        reg [8*128-1:0] lineBuf;
        reg [63:0]      opTok;
        reg [31:0]      a1;
        reg [31:0]      a2;
        reg [31:0]      ex;
        reg [191:0]     nm;
        fd = $fopen("testbench/scan_input.txt", "r");
        if (fd == 0) begin
            $display("Cannot open stimulus file testbench/scan_input.txt");
            stimFails++;
        end else begin
            while (!$feof(fd) && recCount < MAX_RECORDS) begin
                lineBuf = '0;
                n = $fgets(lineBuf, fd);
                // Comment and blank lines do not give five fields
                n = $sscanf(lineBuf, "%s %h %h %h %s", opTok, a1, a2, ex, nm);
                if (n == 5) begin
                    opArr[recCount]   = opTok;
                    arg1Arr[recCount] = a1;
                    arg2Arr[recCount] = a2;
                    expArr[recCount]  = ex;
                    nameArr[recCount] = nm;
                    recCount++;
                end
            end
            $fclose(fd);
        end
    endtask

    //------------------------------------------------------------
    // Stimulus tasks
    //------------------------------------------------------------
    task automatic armCheck(input logic [1:0] kind, input logic [31:0] exp,
                            input logic [191:0] name);
        checkKind <= kind;
        expVal    <= exp;
        checkName <= name;
        checkEn   <= 1'b1;
        @(posedge next);
        checkEn   <= 1'b0;
    endtask

    task automatic busWrite(input logic [7:0] a, input logic [31:0] d);
        @(posedge next);
        addr   <= a;
        dataIn <= d;
        write  <= 1'b1;
        @(posedge next);
        write  <= 1'b0;
    endtask

    task automatic busRead(input logic [7:0] a, input logic [31:0] exp,
                           input logic [191:0] name);
        @(posedge next);
        addr <= a;
        read <= 1'b1;
        @(posedge next);
        read <= 1'b0;
        armCheck(KIND_BUS, exp, name);
    endtask

    task automatic stepOnce;
        @(posedge next);
        step <= 1'b1;
        @(posedge next);
        step <= 1'b0;
    endtask

    task automatic stepAndCheck(input int count, input logic [31:0] exp,
                                input logic [191:0] name);
        int i;
        for (i = 0; i < count; i++) begin
            stepOnce();
        end
        armCheck(KIND_SW, exp, name);
    endtask

    task automatic sendPulse(input int ch, input int width);
        @(posedge next);
        din[ch] <= 1'b1;
        repeat (width) @(posedge next);
        din[ch] <= 1'b0;
        repeat (PULSE_SETTLE) @(posedge next);
    endtask

    // Step until sw shows the channel, then check two cycles later
    task automatic selectChannel(input logic [31:0] ch, input logic [31:0] exp,
                                 input logic [191:0] name);
        int tries;
        tries = 0;
        @(negedge next);
        while (sw != ch[`SCAN_CH_W-1:0] && tries < `SCAN_NUM_CHANNELS) begin
            stepOnce();
            @(negedge next);
            tries++;
        end
        if (sw != ch[`SCAN_CH_W-1:0]) begin
            $display("Test %0s: sw never reached channel %0d", name, ch);
            stimFails++;
        end else begin
            repeat (2) @(posedge next);
            armCheck(KIND_RESULT, exp, name);
        end
    endtask

    task automatic runRecord(input int r);
        if (opArr[r] == "write") begin
            busWrite(arg1Arr[r][7:0], arg2Arr[r]);
        end else if (opArr[r] == "read") begin
            busRead(arg1Arr[r][7:0], expArr[r], nameArr[r]);
        end else if (opArr[r] == "step") begin
            stepAndCheck(arg1Arr[r], expArr[r], nameArr[r]);
        end else if (opArr[r] == "pulse") begin
            sendPulse(arg1Arr[r], arg2Arr[r]);
        end else if (opArr[r] == "select") begin
            selectChannel(arg1Arr[r], expArr[r], nameArr[r]);
        end else begin
            $display("Record %0d has an unknown operation", r);
            stimFails++;
        end
    endtask

    //------------------------------------------------------------
    // Main sequence
    //------------------------------------------------------------
    initial begin
        next       = 1'b0;
        rstN       = 1'b0;
        din        = '0;
        step       = 1'b0;
        addr       = '0;
        dataIn     = '0;
        read       = 1'b0;
        write      = 1'b0;
        checkEn    = 1'b0;
        checkKind  = KIND_BUS;
        expVal     = '0;
        checkName  = '0;
        recCount   = 0;
        cycleCount = 0;
        cycleLimit = 0;
        stimFails  = 0;
        seed       = 32'hf299;
        loadRecords();
        cycleLimit = (recCount > 0 ? recCount : 1) * CYCLES_PER_RECORD;
        repeat (5) @(posedge next);
        rstN <= 1'b1;
        for (idx = 0; idx < recCount; idx++) begin
            gap = 1 + ($unsigned($random(seed)) % 4);
            repeat (gap) @(posedge next);
            runRecord(idx);
        end
        repeat (2) @(posedge next);
        $display("Summary: %0d passed, %0d failed", passCount, failCount + stimFails);
        if (failCount + stimFails == 0 && recCount > 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== testbench/scan_input.txt ====
# op      arg1  arg2      expected  name
# numbers hex; write=addr,data  read=addr  step=count  pulse=channel,width  select=channel
read      c2    0         00012f00  cfgResetValue
step      0     0         00000000  swAfterReset
write     c2    00010805  00000000  cfgWriteSeq
read      c2    0         00010805  cfgReadBack
read      40    0         00000000  otherAddrRead
write     40    ffffffff  00000000  otherAddrWrite
read      c2    0         00010805  cfgUntouched
step      5     0         00000005  seqReachStart
step      1     0         00000006  seqStep6
step      1     0         00000007  seqStep7
step      1     0         00000008  seqStepMax
step      1     0         00000005  seqReload
write     c2    00000805  00000000  cfgIncrOff
step      1     0         00000005  seqHoldOne
step      2     0         00000005  seqHoldTwo
write     c2    00012f00  00000000  cfgFullScan
pulse     3     7         00000000  ch3Pulse
select    3     0         00070001  ch3Result
pulse     14    c         00000000  ch20Pulse
select    14    0         000c0001  ch20Result
pulse     2a    3         00000000  ch42Pulse
select    2a    0         00030001  ch42Result
pulse     14    5         00000000  ch20PulseTwo
select    14    0         00050002  ch20Second
pulse     14    1         00000000  ch20PulseThree
select    14    0         00010003  ch20Third
select    15    0         00000000  ch21Idle
select    1f    0         00000000  ch31Idle
select    2f    0         00000000  ch47Idle
select    3     0         00070001  ch3Kept
